//--- filelist.f
+incdir+verification
src/xr_pkg.sv
src/xr_dpram.sv
src/xr_host_port.sv
src/xr_mem_arb.sv
src/xr_config_regs.sv
src/xr_video_fetch.sv
src/xr_subsystem_top.sv
verification/tb_xr_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the XR subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_xr_subsystem \
    --Mdir "$BUILD_DIR" -o tb_xr_subsystem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_xr_subsystem" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

//--- verification/tb_xr_checks.svh
// Host access and compare tasks

    // word results, host read data and write responses
    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // pixels leaving the video fetch
    task automatic check_pixel(string name, argb_t exp, argb_t act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected argb %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // one host access, the response is held back for hold cycles
    task automatic host_access(logic wr, addr_t addr, word_t wdata, int hold,
                               output word_t rdata);
        xr_rsp_t first;
        @(negedge clk);
        req_i.wr    = wr;
        req_i.addr  = addr;
        req_i.data  = wdata;
        req_valid_i = 1'b1;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        // taken on the rising edge in between
        @(negedge clk);
        req_valid_i = 1'b0;
        while (!rsp_valid_o) begin
            @(negedge clk);
        end
        first = rsp_o;
        repeat (hold) begin
            @(negedge clk);
            check_word("rsp_o", first.data, rsp_o.data);
            if (!rsp_valid_o || req_ready_o) begin
                $display("response dropped or port ready again while rsp_ready_i was low");
                abort_run();
            end
        end
        rsp_ready_i = 1'b1;
        rdata       = rsp_o.data;
        @(negedge clk);
        rsp_ready_i = 1'b0;
    endtask

    task automatic host_write(addr_t addr, word_t data);
        word_t rsp;
        host_access(1'b1, addr, data, 0, rsp);
        // writes answer with zero data
        check_word("rsp_o", '0, rsp);
    endtask

    task automatic host_read(addr_t addr, int hold, output word_t data);
        host_access(1'b0, addr, '0, hold, data);
    endtask

//--- verification/tb_xr_subsystem.sv
// XR subsystem testbench
`timescale 1ns/1ps

module tb_xr_subsystem
    import xr_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_COLOR      = 32;
    localparam int N_TILE       = 16;
    localparam int SCAN_LEN     = 20;
    localparam int N_ACCESS     = 330;
    localparam int N_PIXELS     = 160;
    // rough run length in cycles, host accesses plus pixels under back-pressure
    localparam int TEST_CYCLES  = N_ACCESS * 8 + N_PIXELS * 4;

    logic    clk;
    logic    arst_n_i;
    logic    req_valid_i;
    logic    req_ready_o;
    xr_req_t req_i;
    logic    rsp_valid_o;
    logic    rsp_ready_i;
    xr_rsp_t rsp_o;
    logic    pix_valid_o;
    logic    pix_ready_i;
    argb_t   pix_o;

    // shadow model of the memory map
    word_t      regs_model  [8];
    argb_t      color_model [256];
    word_t      tile0_model [1024];
    word_t      tile1_model [512];
    color_idx_t color_idxs  [$];
    tile_addr_t tile_addrs  [$];
    int         pix_count;

    xr_subsystem_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TEST_CYCLES * 20 * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 20);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_xr_checks.svh"

    // bank 1 holds 512 words, so bit 9 is ignored there
    function automatic word_t tile_model_read(tile_addr_t a);
        if (a[TILE_W-1]) begin
            return tile1_model[a[TILE2_W-1:0]];
        end
        return tile0_model[a[TILE_W-2:0]];
    endfunction

    // pixel n of the scan, length zero counts as one
    function automatic argb_t expected_pixel(int n);
        int         len;
        tile_addr_t addr;
        word_t      tile;
        len  = (regs_model[REG_VID_LEN] == '0) ? 1 : int'(regs_model[REG_VID_LEN]);
        addr = regs_model[REG_VID_BASE][TILE_W-1:0] + tile_addr_t'(n % len);
        tile = tile_model_read(addr);
        return color_model[tile[COLOR_W-1:0]];
    endfunction

    task automatic write_reg(int r, word_t v);
        host_write(addr_t'(r), v);
        regs_model[r] = v;
    endtask

    task automatic load_color(color_idx_t i, argb_t c);
        host_write({XR_COLOR_REGION, 6'd0, i}, word_t'(c));
        color_model[i] = c;
    endtask

    task automatic load_tile(tile_addr_t a, word_t v);
        host_write({XR_TILE_REGION, 3'd0, a}, v);
        if (a[TILE_W-1]) begin
            tile1_model[a[TILE2_W-1:0]] = v;
        end else begin
            tile0_model[a[TILE_W-2:0]] = v;
        end
    endtask

    task automatic verify_reg(int r, int hold);
        word_t d;
        host_read(addr_t'(r), hold, d);
        check_word("reg rsp_o", regs_model[r], d);
    endtask

    task automatic verify_color(color_idx_t i, int hold);
        word_t d;
        host_read({XR_COLOR_REGION, 6'd0, i}, hold, d);
        check_word("color rsp_o", word_t'(color_model[i]), d);
    endtask

    task automatic verify_tile(tile_addr_t a, int hold);
        word_t d;
        host_read({XR_TILE_REGION, 3'd0, a}, hold, d);
        check_word("tile rsp_o", tile_model_read(a), d);
    endtask

    task automatic start_video();
        pix_count = 0;
        write_reg(REG_VID_CTRL, 16'h0001);
    endtask

    // in-flight reads land in the FIFO, then the sink empties it
    task automatic stop_video();
        write_reg(REG_VID_CTRL, 16'h0000);
        repeat (4) @(negedge clk);
        while (pix_valid_o) begin
            @(negedge clk);
        end
    endtask

    // pixel sink with random back-pressure
    always @(negedge clk) begin
        if (arst_n_i) begin
            pix_ready_i = 1'($urandom);
            if (pix_valid_o && pix_ready_i) begin
                check_pixel("pix_o", expected_pixel(pix_count), pix_o);
                pix_count++;
            end
        end
    end

    task automatic regs_readback();
        for (int pass = 0; pass < 2; pass++) begin
            for (int r = 3; r < 8; r++) begin
                write_reg(r, word_t'($urandom));
            end
        end
        for (int r = 7; r >= 3; r--) begin
            verify_reg(r, 0);
        end
    endtask

    task automatic color_ram_readback();
        for (int i = 0; i < N_COLOR; i++) begin
            color_idxs.push_back(color_idx_t'($urandom));
            load_color(color_idxs[i], argb_t'($urandom));
        end
        for (int i = N_COLOR - 1; i >= 0; i--) begin
            verify_color(color_idxs[i], 0);
        end
    endtask

    task automatic tile_ram_readback();
        tile_addr_t a;
        for (int i = 0; i < N_TILE; i++) begin
            a = tile_addr_t'($urandom_range(1023));
            tile_addrs.push_back(a);
            load_tile(a, word_t'($urandom));
            // same bank 1 word under both of its aliases
            a = tile_addr_t'(11'h400 | 11'($urandom_range(511)));
            tile_addrs.push_back(a);
            tile_addrs.push_back(a ^ 11'h200);
            load_tile(a, word_t'($urandom));
            load_tile(a ^ 11'h200, word_t'($urandom));
        end
        foreach (tile_addrs[i]) begin
            verify_tile(tile_addrs[i], 0);
        end
    endtask

    task automatic video_stream();
        tile_addr_t base;
        // scan crosses from bank 0 into bank 1
        base = 11'h3f8;
        for (int i = 0; i < SCAN_LEN; i++) begin
            load_tile(base + tile_addr_t'(i),
                      {8'($urandom), color_idxs[$urandom_range(N_COLOR - 1)]});
        end
        write_reg(REG_VID_BASE, word_t'(base));
        write_reg(REG_VID_LEN, word_t'(SCAN_LEN));
        start_video();
        wait (pix_count >= 3 * SCAN_LEN);
        stop_video();
        // zero length repeats the first tile
        write_reg(REG_VID_LEN, '0);
        start_video();
        wait (pix_count >= 8);
        stop_video();
        write_reg(REG_VID_LEN, word_t'(SCAN_LEN));
    endtask

    task automatic reads_during_video();
        start_video();
        foreach (color_idxs[i]) begin
            verify_color(color_idxs[i], 0);
        end
        foreach (tile_addrs[i]) begin
            verify_tile(tile_addrs[i], 0);
        end
        if (pix_count == 0) begin
            $display("no pixels came out while the host reads ran");
            abort_run();
        end
        stop_video();
    endtask

    task automatic response_backpressure();
        for (int i = 0; i < 4; i++) begin
            verify_color(color_idxs[i], $urandom_range(12, 1));
            verify_tile(tile_addrs[i], $urandom_range(12, 1));
        end
        verify_reg(5, $urandom_range(12, 1));
    endtask

    initial begin
        void'($urandom(32'hf6ce_df47));
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        pix_ready_i = 1'b0;
        pix_count   = 0;
        foreach (regs_model[i]) begin
            regs_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        regs_readback();
        color_ram_readback();
        tile_ram_readback();
        video_stream();
        reads_during_video();
        response_backpressure();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src/xr_subsystem_top.sv
// XR memory subsystem top
`timescale 1ns/1ps

module xr_subsystem_top
    import xr_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,

    // host access
    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  xr_req_t req_i,
    output logic    rsp_valid_o,
    input  logic    rsp_ready_i,
    output xr_rsp_t rsp_o,

    // pixel stream
    output logic    pix_valid_o,
    input  logic    pix_ready_i,
    output argb_t   pix_o
);

    // host port to arbiter
    logic       xr_sel;
    logic       xr_wr;
    addr_t      xr_addr;
    word_t      xr_data;
    logic       xr_ack;
    word_t      xr_rdata;

    // register bus
    logic       xreg_wr;
    logic [2:0] xreg_addr;
    word_t      xreg_wdata;
    word_t      xreg_rdata;

    // video control and RAM reads
    logic       vid_enable;
    tile_addr_t vid_base;
    word_t      vid_len;
    logic       vgen_tile_sel;
    tile_addr_t vgen_tile_addr;
    word_t      vgen_tile_data;
    logic       vgen_color_sel;
    color_idx_t vgen_color_addr;
    argb_t      vgen_color_data;

    xr_host_port u_host_port (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .xr_sel_o    (xr_sel),
        .xr_wr_o     (xr_wr),
        .xr_addr_o   (xr_addr),
        .xr_data_o   (xr_data),
        .xr_ack_i    (xr_ack),
        .xr_rdata_i  (xr_rdata)
    );

    xr_mem_arb u_mem_arb (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .xr_sel_i          (xr_sel),
        .xr_ack_o          (xr_ack),
        .xr_wr_i           (xr_wr),
        .xr_addr_i         (xr_addr),
        .xr_data_i         (xr_data),
        .xr_data_o         (xr_rdata),
        .xreg_wr_o         (xreg_wr),
        .xreg_addr_o       (xreg_addr),
        .xreg_data_o       (xreg_wdata),
        .xreg_data_i       (xreg_rdata),
        .vgen_color_sel_i  (vgen_color_sel),
        .vgen_color_addr_i (vgen_color_addr),
        .vgen_color_data_o (vgen_color_data),
        .vgen_tile_sel_i   (vgen_tile_sel),
        .vgen_tile_addr_i  (vgen_tile_addr),
        .vgen_tile_data_o  (vgen_tile_data)
    );

    xr_config_regs u_config_regs (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .xreg_wr_i    (xreg_wr),
        .xreg_addr_i  (xreg_addr),
        .xreg_data_i  (xreg_wdata),
        .xreg_data_o  (xreg_rdata),
        .vid_enable_o (vid_enable),
        .vid_base_o   (vid_base),
        .vid_len_o    (vid_len)
    );

    xr_video_fetch u_video_fetch (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .vid_enable_i      (vid_enable),
        .vid_base_i        (vid_base),
        .vid_len_i         (vid_len),
        .vgen_tile_sel_o   (vgen_tile_sel),
        .vgen_tile_addr_o  (vgen_tile_addr),
        .vgen_tile_data_i  (vgen_tile_data),
        .vgen_color_sel_o  (vgen_color_sel),
        .vgen_color_addr_o (vgen_color_addr),
        .vgen_color_data_i (vgen_color_data),
        .pix_valid_o       (pix_valid_o),
        .pix_ready_i       (pix_ready_i),
        .pix_o             (pix_o)
    );

endmodule

//--- src/xr_video_fetch.sv
// Tile video fetch
`timescale 1ns/1ps

module xr_video_fetch
    import xr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,

    // control from the config registers
    input  logic       vid_enable_i,
    input  tile_addr_t vid_base_i,
    input  word_t      vid_len_i,

    // tile RAM read
    output logic       vgen_tile_sel_o,
    output tile_addr_t vgen_tile_addr_o,
    input  word_t      vgen_tile_data_i,

    // color RAM read
    output logic       vgen_color_sel_o,
    output color_idx_t vgen_color_addr_o,
    input  argb_t      vgen_color_data_i,

    // pixel stream
    output logic       pix_valid_o,
    input  logic       pix_ready_i,
    output argb_t      pix_o
);

    localparam int PTR_W = $clog2(PIX_FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    tile_addr_t       scan_addr;
    word_t            scan_cnt;
    logic [16:0]      scan_next;
    logic             scan_last;
    logic             issue;
    logic             tile_vld;
    logic             color_vld;
    logic [CNT_W-1:0] credit_used;
    logic             push;
    logic             pop;
    argb_t            fifo_mem [PIX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;

    // stored pixels plus reads still in flight
    assign credit_used = fifo_cnt + CNT_W'(tile_vld) + CNT_W'(color_vld);
    assign issue       = vid_enable_i && (credit_used < CNT_W'(PIX_FIFO_DEPTH));

    // a length of zero ends every scan after one pixel
    assign scan_next = {1'b0, scan_cnt} + 17'd1;
    assign scan_last = (scan_next >= {1'b0, vid_len_i});

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scan_addr <= '0;
            scan_cnt  <= '0;
        end else if (!vid_enable_i || (issue && scan_last)) begin
            scan_addr <= vid_base_i;
            scan_cnt  <= '0;
        end else if (issue) begin
            scan_addr <= scan_addr + 1'b1;
            scan_cnt  <= scan_next[15:0];
        end
    end

    // two stage read pipeline, tile then color
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tile_vld  <= 1'b0;
            color_vld <= 1'b0;
        end else begin
            tile_vld  <= issue;
            color_vld <= tile_vld;
        end
    end

    assign vgen_tile_sel_o   = issue;
    assign vgen_tile_addr_o  = scan_addr;
    assign vgen_color_sel_o  = tile_vld;
    assign vgen_color_addr_o = vgen_tile_data_i[COLOR_W-1:0];

    // pixel FIFO
    assign push        = color_vld;
    assign pop         = pix_valid_o && pix_ready_i;
    assign pix_valid_o = (fifo_cnt != '0);
    assign pix_o       = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= vgen_color_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // credit check must keep room for every read in flight
    a_fifo_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (push && !pop) |-> (fifo_cnt < CNT_W'(PIX_FIFO_DEPTH))
    );

endmodule

//--- src/xr_config_regs.sv
// XR configuration registers
`timescale 1ns/1ps

module xr_config_regs
    import xr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,

    // register bus from the arbiter
    input  logic       xreg_wr_i,
    input  logic [2:0] xreg_addr_i,
    input  word_t      xreg_data_i,
    output word_t      xreg_data_o,

    // video control fields
    output logic       vid_enable_o,
    output tile_addr_t vid_base_o,
    output word_t      vid_len_o
);

    word_t regs [8];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (xreg_wr_i) begin
            regs[xreg_addr_i] <= xreg_data_i;
        end
    end

    // read back is combinational
    assign xreg_data_o = regs[xreg_addr_i];

    assign vid_enable_o = regs[REG_VID_CTRL][0];
    assign vid_base_o   = regs[REG_VID_BASE][TILE_W-1:0];
    assign vid_len_o    = regs[REG_VID_LEN];

endmodule

//--- src/xr_mem_arb.sv
// XR memory arbiter
`timescale 1ns/1ps

module xr_mem_arb
    import xr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,

    // host XR bus
    input  logic       xr_sel_i,
    output logic       xr_ack_o,
    input  logic       xr_wr_i,
    input  addr_t      xr_addr_i,
    input  word_t      xr_data_i,
    output word_t      xr_data_o,

    // configuration register bus
    output logic       xreg_wr_o,
    output logic [2:0] xreg_addr_o,
    output word_t      xreg_data_o,
    input  word_t      xreg_data_i,

    // read-only video color lookup
    input  logic       vgen_color_sel_i,
    input  color_idx_t vgen_color_addr_i,
    output argb_t      vgen_color_data_o,

    // read-only video tile fetch
    input  logic       vgen_tile_sel_i,
    input  tile_addr_t vgen_tile_addr_i,
    output word_t      vgen_tile_data_o
);

    logic       regs_sel;
    logic       color_sel;
    logic       tile_sel;
    logic       host_pend;
    logic       wr_ack_next;
    logic       xreg_rd_ack_next;
    logic       color_rd_ack_next;
    logic       tile_rd_ack_next;
    logic       color_wr_en;
    logic       tile_wr_en;
    color_idx_t color_rd_addr;
    argb_t      color_rd_data;
    tile_addr_t tile_rd_addr;
    logic       tile_bank_q;
    word_t      tile0_rd_data;
    word_t      tile1_rd_data;
    word_t      tile_rd_data;

    // region decode
    assign regs_sel  = (xr_addr_i[15] == XR_REGS_REGION);
    assign color_sel = (xr_addr_i[15:14] == XR_COLOR_REGION);
    assign tile_sel  = (xr_addr_i[15:14] == XR_TILE_REGION);

    // sel still high during the ack cycle, so mask it there
    assign host_pend = xr_sel_i & ~xr_ack_o;

    // writes go straight through since they never conflict
    always_comb begin
        wr_ack_next = host_pend & xr_wr_i;
        color_wr_en = wr_ack_next & color_sel;
        tile_wr_en  = wr_ack_next & tile_sel;
    end

    assign xreg_wr_o        = host_pend & xr_wr_i & regs_sel;
    assign xreg_addr_o      = xr_addr_i[2:0];
    assign xreg_data_o      = xr_data_i;
    assign xreg_rd_ack_next = host_pend & ~xr_wr_i & regs_sel;

    // video gets the color read port first
    always_comb begin
        color_rd_ack_next = 1'b0;
        color_rd_addr     = vgen_color_addr_i;
        if (!vgen_color_sel_i && host_pend) begin
            color_rd_ack_next = color_sel & ~xr_wr_i;
            color_rd_addr     = xr_addr_i[COLOR_W-1:0];
        end
    end

    // video gets the tile read port first
    always_comb begin
        tile_rd_ack_next = 1'b0;
        tile_rd_addr     = vgen_tile_addr_i;
        if (!vgen_tile_sel_i && host_pend) begin
            tile_rd_ack_next = tile_sel & ~xr_wr_i;
            tile_rd_addr     = xr_addr_i[TILE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            xr_ack_o    <= 1'b0;
            tile_bank_q <= 1'b0;
        end else begin
            xr_ack_o    <= wr_ack_next | xreg_rd_ack_next | color_rd_ack_next
                           | tile_rd_ack_next;
            // bank of the read now in the RAM output register
            tile_bank_q <= tile_rd_addr[TILE_W-1];
        end
    end

    assign tile_rd_data      = tile_bank_q ? tile1_rd_data : tile0_rd_data;
    assign vgen_tile_data_o  = tile_rd_data;
    assign vgen_color_data_o = color_rd_data;

    // host read data is valid in the ack cycle
    always_comb begin
        xr_data_o = xreg_data_i;
        if (color_sel) begin
            xr_data_o = word_t'(color_rd_data);
        end else if (tile_sel) begin
            xr_data_o = tile_rd_data;
        end
    end

    xr_dpram #(
        .AWIDTH    (COLOR_W),
        .payload_t (argb_t)
    ) u_color_ram (
        .clk       (clk),
        .wr_en_i   (color_wr_en),
        .wr_addr_i (xr_addr_i[COLOR_W-1:0]),
        .wr_data_i (argb_t'(xr_data_i)),
        .rd_addr_i (color_rd_addr),
        .rd_data_o (color_rd_data)
    );

    // bank 0 holds 1024 words
    xr_dpram #(
        .AWIDTH    (TILE_W-1),
        .payload_t (word_t)
    ) u_tile_ram0 (
        .clk       (clk),
        .wr_en_i   (tile_wr_en & ~xr_addr_i[TILE_W-1]),
        .wr_addr_i (xr_addr_i[TILE_W-2:0]),
        .wr_data_i (xr_data_i),
        .rd_addr_i (tile_rd_addr[TILE_W-2:0]),
        .rd_data_o (tile0_rd_data)
    );

    // bank 1 is smaller and aliases every 512 words
    xr_dpram #(
        .AWIDTH    (TILE2_W),
        .payload_t (word_t)
    ) u_tile_ram1 (
        .clk       (clk),
        .wr_en_i   (tile_wr_en & xr_addr_i[TILE_W-1]),
        .wr_addr_i (xr_addr_i[TILE2_W-1:0]),
        .wr_data_i (xr_data_i),
        .rd_addr_i (tile_rd_addr[TILE2_W-1:0]),
        .rd_data_o (tile1_rd_data)
    );

    // the host keeps sel and its fields steady until the ack
    a_sel_held_until_ack: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (xr_sel_i && !xr_ack_o) |=> (xr_sel_i && $stable(xr_wr_i)
                                     && $stable(xr_addr_i) && $stable(xr_data_i))
    );

endmodule

//--- src/xr_host_port.sv
// Host request port
`timescale 1ns/1ps

module xr_host_port
    import xr_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,

    // host request side
    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  xr_req_t req_i,

    // host response side
    output logic    rsp_valid_o,
    input  logic    rsp_ready_i,
    output xr_rsp_t rsp_o,

    // XR sel/ack bus towards the arbiter
    output logic    xr_sel_o,
    output logic    xr_wr_o,
    output addr_t   xr_addr_o,
    output word_t   xr_data_o,
    input  logic    xr_ack_i,
    input  word_t   xr_rdata_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_RESP
    } state_t;

    state_t  state;
    xr_req_t req_q;
    xr_rsp_t rsp_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req_valid_i) state <= ST_BUSY;
                ST_BUSY: if (xr_ack_i) state <= ST_RESP;
                ST_RESP: if (rsp_ready_i) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request held stable for the whole sel phase
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if (xr_sel_o && xr_ack_i) begin
            rsp_q.data <= req_q.wr ? '0 : xr_rdata_i;
        end
    end

    assign req_ready_o = (state == ST_IDLE);
    assign rsp_valid_o = (state == ST_RESP);
    assign rsp_o       = rsp_q;

    assign xr_sel_o  = (state == ST_BUSY);
    assign xr_wr_o   = req_q.wr;
    assign xr_addr_o = req_q.addr;
    assign xr_data_o = req_q.data;

    // the arbiter only acknowledges an access that is still selected
    a_ack_needs_sel: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        xr_ack_i |-> xr_sel_o
    );

endmodule

//--- src/xr_dpram.sv
// Dual port block RAM
`timescale 1ns/1ps

module xr_dpram #(
    parameter int  AWIDTH    = 8,
    parameter type payload_t = logic [15:0]
) (
    input  logic              clk,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  payload_t          wr_data_i,
    input  logic [AWIDTH-1:0] rd_addr_i,
    output payload_t          rd_data_o
);

    payload_t mem [2**AWIDTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- src/xr_pkg.sv
// XR memory block definitions
package xr_pkg;

    // host data word and XR address
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // pixel color, one nibble per channel
    typedef struct packed {
        logic [3:0] a;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } argb_t;

    // color RAM has 256 entries
    localparam int COLOR_W = 8;
    // tile space: bit 10 picks the bank, bank 1 is only 512 words
    localparam int TILE_W  = 11;
    localparam int TILE2_W = 9;

    typedef logic [COLOR_W-1:0] color_idx_t;
    typedef logic [TILE_W-1:0]  tile_addr_t;

    // region decode on addr[15:14], registers only look at bit 15
    localparam logic       XR_REGS_REGION  = 1'b0;
    localparam logic [1:0] XR_COLOR_REGION = 2'b10;
    localparam logic [1:0] XR_TILE_REGION  = 2'b11;

    // configuration register indices, 3 to 7 are scratch
    localparam int REG_VID_CTRL = 0;
    localparam int REG_VID_BASE = 1;
    localparam int REG_VID_LEN  = 2;

    // pixel output slots in the video fetch
    localparam int PIX_FIFO_DEPTH = 4;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
    } xr_req_t;

    // writes return zero data
    typedef struct packed {
        word_t data;
    } xr_rsp_t;

endpackage
